// ==== imuldiv_unit.f ====
imuldiv_pkg.sv
int_mul_iterative.sv
int_div_iterative.sv
imuldiv_order_ctrl.sv
imuldiv_unit.sv
imuldiv_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the mul/div unit testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
  --top-module imuldiv_unit_tb -f imuldiv_unit.f -o imuldiv_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/imuldiv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
  echo "test run reported a failure, see $LOG"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

exit 0

// ==== imuldiv_unit_tb.sv ====
/*
 * random-stimulus testbench for the mul/div unit against a reference model
 * responses are matched in acceptance order within a fixed cycle limit
 */
module imuldiv_unit_tb import imuldiv_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  // random requests in the mixed phase
  localparam int NUM_REQ        = 400;
  localparam int TIMEOUT_CYCLES = NUM_REQ * 40 + 200;

  logic        clk;
  logic        reset;
  logic        req_val;
  logic        req_rdy;
  imuldiv_fn_e req_fn;
  operand_t    req_a;
  operand_t    req_b;
  logic        resp_val;
  logic        resp_rdy;
  result_t     resp_result;

  int          cyc = 0;
  logic [31:0] lfsr_state = 32'h97fd;

  // expected results in acceptance order
  result_t     exp_q[$];
  imuldiv_fn_e fn_q[$];

  imuldiv_unit imuldiv_unit_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // ------------------------------------------------------------
  // clock, cycle count, watchdog
  // ------------------------------------------------------------
  initial begin : clock_gen
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  initial begin : watchdog
    wait (cyc >= TIMEOUT_CYCLES);
    abort_run("timeout, the run did not finish within the cycle limit");
  end

  // ------------------------------------------------------------
  // random numbers
  // ------------------------------------------------------------
  // 32-bit fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // corner values show up often and zero doubles as a zero divisor
  function automatic operand_t pick_operand();
    int sel;
    operand_t v;
    sel = int'(take_bits(3));
    case (sel)
      0: v = 32'h0000_0000;
      1: v = 32'h8000_0000;
      2: v = 32'hffff_ffff;
      3: v = take_bits(8);
      4: v = 32'h0000_0001;
      default: v = take_bits(32);
    endcase
    return v;
  endfunction

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  // divide results are {remainder, quotient}
  function automatic result_t expected_result(input imuldiv_fn_e fn, input operand_t a,
                                              input operand_t b);
    longint  sa;
    longint  sb;
    longint  q;
    longint  r;
    result_t res;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (fn == FN_MUL) begin
      res = sa * sb;
    end else if (b == 32'h0) begin
      // zero divisor gives an all-ones quotient and the dividend as remainder
      res = {a, 32'hffff_ffff};
    end else if (fn == FN_DIV) begin
      // truncating divide where the remainder follows the dividend sign
      q   = sa / sb;
      r   = sa % sb;
      res = {r[31:0], q[31:0]};
    end else begin
      res = {a % b, a / b};
    end
    return res;
  endfunction

  // ------------------------------------------------------------
  // checking
  // ------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  // single request on an idle unit with latency counted from the accept edge
  task automatic lone_op(input imuldiv_fn_e fn, input operand_t a, input operand_t b,
                         input int latency);
    int      accept_edge;
    result_t expected;
    expected = expected_result(fn, a, b);
    @(posedge clk);
    #2;
    req_val  = 1'b1;
    req_fn   = fn;
    req_a    = a;
    req_b    = b;
    resp_rdy = 1'b1;
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    accept_edge = cyc + 1;
    @(posedge clk);
    #2;
    req_val = 1'b0;
    @(negedge clk);
    while (!resp_val) @(negedge clk);
    check_value($sformatf("%s latency", fn.name()), 64'(latency), 64'(cyc - accept_edge));
    check_value($sformatf("%s lone result", fn.name()), expected, resp_result);
    // transfer happens at this edge
    @(posedge clk);
    #2;
    resp_rdy = 1'b0;
  endtask

  task automatic drive_request();
    int pick;
    pick = int'(take_bits(2));
    case (pick)
      1: req_fn = FN_DIV;
      2: req_fn = FN_DIVU;
      default: req_fn = FN_MUL;
    endcase
    req_a   = pick_operand();
    req_b   = pick_operand();
    req_val = 1'b1;
  endtask

  // interleaved traffic with back-pressure sampled mid-cycle
  task automatic run_random();
    int          sent;
    int          received;
    logic        accepted;
    logic        responded;
    imuldiv_fn_e fn;
    result_t     expected;
    sent     = 0;
    received = 0;
    while (received < NUM_REQ) begin
      @(negedge clk);
      accepted  = req_val && req_rdy;
      responded = resp_val && resp_rdy;
      // pop first since a response always belongs to an older request
      if (responded) begin
        if (exp_q.size() == 0) begin
          abort_run("a response arrived with no request outstanding");
        end
        expected = exp_q.pop_front();
        fn       = fn_q.pop_front();
        check_value($sformatf("%s response %0d", fn.name(), received), expected, resp_result);
        received++;
      end
      if (accepted) begin
        exp_q.push_back(expected_result(req_fn, req_a, req_b));
        fn_q.push_back(req_fn);
        sent++;
        check_value("outstanding within queue depth", 64'(1),
                    64'(exp_q.size() <= ORDER_DEPTH));
      end
      @(posedge clk);
      #2;
      // a request is held until taken so gaps fall only between requests
      if (accepted || !req_val) begin
        if (sent < NUM_REQ && take_bits(3) != 32'h0) begin
          drive_request();
        end else begin
          req_val = 1'b0;
        end
      end
      resp_rdy = (take_bits(2) != 32'h0);
    end
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin : stimulus
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = FN_MUL;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;

    @(negedge clk);
    check_value("req_rdy after reset", 64'(1), 64'(req_rdy));
    check_value("resp_val after reset", 64'(0), 64'(resp_val));

    // corner cases on an idle unit
    lone_op(FN_MUL, 32'h8000_0000, 32'h8000_0000, 33);
    lone_op(FN_MUL, 32'hffff_fff9, 32'h0001_e240, 33);
    lone_op(FN_DIV, 32'h8000_0000, 32'hffff_ffff, 34);
    lone_op(FN_DIV, 32'hffff_ff9c, 32'h0000_0000, 34);
    lone_op(FN_DIVU, 32'hffff_fff0, 32'h0000_0000, 34);

    run_random();

    // nothing may follow the last response
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    repeat (40) begin
      @(negedge clk);
      check_value("resp_val after drain", 64'(0), 64'(resp_val));
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== imuldiv_unit.sv ====
/*
 * mul/div unit top, one multiply and one divide may be in flight
 * responses return strictly in the order requests were accepted
 */
module imuldiv_unit import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        req_val,
  output logic        req_rdy,
  input  imuldiv_fn_e req_fn,
  input  operand_t    req_a,
  input  operand_t    req_b,
  output logic        resp_val,
  input  logic        resp_rdy,
  output result_t     resp_result
);

  // multiplier side
  logic    mul_req_val;
  logic    mul_req_rdy;
  logic    mul_resp_val;
  logic    mul_resp_rdy;
  result_t mul_resp_result;

  // divider side
  logic    div_req_val;
  logic    div_req_rdy;
  logic    div_resp_val;
  logic    div_resp_rdy;
  result_t div_resp_result;

  // ------------------------------------------------------------
  // arithmetic units, operands fan out to both
  // ------------------------------------------------------------
  int_mul_iterative mul_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy),
    .resp_result (mul_resp_result)
  );

  int_div_iterative div_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy),
    .resp_result (div_resp_result)
  );

  // steering and in-order return
  imuldiv_order_ctrl order_i (
    .clk             (clk),
    .reset           (reset),
    .req_val         (req_val),
    .req_fn          (req_fn),
    .req_rdy         (req_rdy),
    .mul_req_val     (mul_req_val),
    .mul_req_rdy     (mul_req_rdy),
    .div_req_val     (div_req_val),
    .div_req_rdy     (div_req_rdy),
    .mul_resp_val    (mul_resp_val),
    .mul_resp_result (mul_resp_result),
    .mul_resp_rdy    (mul_resp_rdy),
    .div_resp_val    (div_resp_val),
    .div_resp_result (div_resp_result),
    .div_resp_rdy    (div_resp_rdy),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy),
    .resp_result     (resp_result)
  );

endmodule

// ==== imuldiv_order_ctrl.sv ====
/*
 * steers requests by function code and returns responses in accept order
 * purely combinational on the request and response paths
 */
module imuldiv_order_ctrl import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        req_val,
  input  imuldiv_fn_e req_fn,
  output logic        req_rdy,
  output logic        mul_req_val,
  input  logic        mul_req_rdy,
  output logic        div_req_val,
  input  logic        div_req_rdy,
  input  logic        mul_resp_val,
  input  result_t     mul_resp_result,
  output logic        mul_resp_rdy,
  input  logic        div_resp_val,
  input  result_t     div_resp_result,
  output logic        div_resp_rdy,
  output logic        resp_val,
  input  logic        resp_rdy,
  output result_t     resp_result
);

  // tag queue, one entry per outstanding request
  unit_sel_t  order_q [ORDER_DEPTH];
  order_ptr_t wr_ptr;
  order_ptr_t rd_ptr;
  order_cnt_t count;

  logic      q_full;
  logic      q_empty;
  logic      is_mul;
  logic      target_rdy;
  logic      push;
  logic      pop;
  unit_sel_t head;

  assign q_full  = (count == order_cnt_t'(ORDER_DEPTH));
  assign q_empty = (count == '0);
  assign head    = order_q[rd_ptr];

  // ------------------------------------------------------------
  // request steering
  // ------------------------------------------------------------
  // anything other than mul goes to the divider
  assign is_mul     = (req_fn == FN_MUL);
  assign target_rdy = is_mul ? mul_req_rdy : div_req_rdy;

  assign req_rdy     = target_rdy && !q_full;
  assign mul_req_val = req_val && is_mul && !q_full;
  assign div_req_val = req_val && !is_mul && !q_full;

  assign push = req_val && req_rdy;

  // ------------------------------------------------------------
  // response select
  // ------------------------------------------------------------
  // only the unit named at the head may hand over its result
  assign resp_val    = !q_empty && ((head == UNIT_DIV) ? div_resp_val : mul_resp_val);
  assign resp_result = (head == UNIT_DIV) ? div_resp_result : mul_resp_result;

  assign mul_resp_rdy = !q_empty && (head == UNIT_MUL) && resp_rdy;
  assign div_resp_rdy = !q_empty && (head == UNIT_DIV) && resp_rdy;

  assign pop = resp_val && resp_rdy;

  // ------------------------------------------------------------
  // queue state
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + order_ptr_t'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + order_ptr_t'(1);
      end
      // push and pop together leave the count unchanged
      if (push && !pop) begin
        count <= count + order_cnt_t'(1);
      end else if (pop && !push) begin
        count <= count - order_cnt_t'(1);
      end
    end
  end

  // tag storage
  always_ff @(posedge clk) begin
    if (push) begin
      order_q[wr_ptr] <= is_mul ? UNIT_MUL : UNIT_DIV;
    end
  end

endmodule

// ==== int_div_iterative.sv ====
/*
 * 32-bit restoring divider, signed or unsigned, result is {rem, quo}
 * divide by zero gives quo all ones and rem equal to the dividend
 */
module int_div_iterative import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        req_val,
  output logic        req_rdy,
  input  imuldiv_fn_e req_fn,
  input  operand_t    req_a,
  input  operand_t    req_b,
  output logic        resp_val,
  input  logic        resp_rdy,
  output result_t     resp_result
);

  div_state_e  state;
  iter_count_t count;

  // datapath registers
  operand_t rem_reg;      // partial remainder
  operand_t quo_reg;      // dividend bits shift out, quotient bits shift in
  operand_t divisor_reg;
  logic     quo_neg;
  logic     rem_neg;
  logic     div_zero;

  logic req_go;
  logic resp_go;
  logic calc_last;
  logic calc_step;
  logic is_signed;

  operand_t a_mag;
  operand_t b_mag;

  logic [32:0] rem_shift;
  logic [33:0] rem_diff;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------
  assign req_rdy  = (state == DIV_IDLE);
  assign resp_val = (state == DIV_DONE);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;

  assign calc_last = (count == iter_count_t'(ITER_COUNT));
  assign calc_step = (state == DIV_CALC) && !calc_last;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= DIV_IDLE;
      count <= '0;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (req_go) begin
            state <= DIV_CALC;
            count <= '0;
          end
        end
        DIV_CALC: begin
          if (calc_last) begin
            state <= DIV_FIX;
          end else begin
            count <= count + iter_count_t'(1);
          end
        end
        // one cycle for sign and zero-divisor correction
        DIV_FIX: state <= DIV_DONE;
        DIV_DONE: begin
          if (resp_go) begin
            state <= DIV_IDLE;
          end
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // operand conditioning
  // ------------------------------------------------------------
  assign is_signed = (req_fn == FN_DIV);

  // unsigned divide uses operands as they are
  assign a_mag = (is_signed && req_a[31]) ? operand_t'(-req_a) : req_a;
  assign b_mag = (is_signed && req_b[31]) ? operand_t'(-req_b) : req_b;

  // ------------------------------------------------------------
  // restoring step
  // ------------------------------------------------------------
  // next dividend bit enters from the top of quo_reg
  assign rem_shift = {rem_reg, quo_reg[31]};
  assign rem_diff  = {1'b0, rem_shift} - {2'b0, divisor_reg};

  always_ff @(posedge clk) begin
    if (req_go) begin
      rem_reg     <= '0;
      quo_reg     <= a_mag;
      divisor_reg <= b_mag;
      quo_neg     <= is_signed && (req_a[31] ^ req_b[31]);
      rem_neg     <= is_signed && req_a[31];
      div_zero    <= (req_b == '0);
    end else if (calc_step) begin
      if (rem_diff[33]) begin
        // would go negative, keep the shifted remainder
        rem_reg <= rem_shift[31:0];
        quo_reg <= {quo_reg[30:0], 1'b0};
      end else begin
        rem_reg <= rem_diff[31:0];
        quo_reg <= {quo_reg[30:0], 1'b1};
      end
    end else if (state == DIV_FIX) begin
      // zero divisor leaves the dividend magnitude in rem_reg, so the
      // remainder sign fix alone restores the original dividend
      if (div_zero) begin
        quo_reg <= '1;
      end else if (quo_neg) begin
        quo_reg <= operand_t'(-quo_reg);
      end
      if (rem_neg) begin
        rem_reg <= operand_t'(-rem_reg);
      end
    end
  end

  assign resp_result = {rem_reg, quo_reg};

endmodule

// ==== int_mul_iterative.sv ====
/*
 * signed 32x32 shift-add multiplier, one product bit per cycle
 * response appears 33 cycles after acceptance, no early exit
 */
module int_mul_iterative import imuldiv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     req_val,
  output logic     req_rdy,
  input  operand_t req_a,
  input  operand_t req_b,
  output logic     resp_val,
  input  logic     resp_rdy,
  output result_t  resp_result
);

  mul_state_e  state;
  iter_count_t count;

  // datapath registers
  result_t  mcand_reg;   // multiplicand, shifts left
  operand_t mplier_reg;  // multiplier, shifts right
  result_t  acc_reg;
  logic     neg_reg;     // product sign

  logic req_go;
  logic resp_go;
  logic calc_last;
  logic calc_step;

  operand_t a_mag;
  operand_t b_mag;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------
  assign req_rdy  = (state == MUL_IDLE);
  assign resp_val = (state == MUL_DONE);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;

  // after 32 steps the counter sits at ITER_COUNT for one more cycle
  assign calc_last = (count == iter_count_t'(ITER_COUNT));
  assign calc_step = (state == MUL_CALC) && !calc_last;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= MUL_IDLE;
      count <= '0;
    end else begin
      case (state)
        MUL_IDLE: begin
          if (req_go) begin
            state <= MUL_CALC;
            count <= '0;
          end
        end
        MUL_CALC: begin
          if (calc_last) begin
            state <= MUL_DONE;
          end else begin
            count <= count + iter_count_t'(1);
          end
        end
        MUL_DONE: begin
          // hold result until the consumer takes it
          if (resp_go) begin
            state <= MUL_IDLE;
          end
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------
  // magnitudes, most negative value maps to 0x80000000 unsigned
  assign a_mag = req_a[31] ? operand_t'(-req_a) : req_a;
  assign b_mag = req_b[31] ? operand_t'(-req_b) : req_b;

  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand_reg  <= {32'b0, a_mag};
      mplier_reg <= b_mag;
      acc_reg    <= '0;
      neg_reg    <= req_a[31] ^ req_b[31];
    end else if (calc_step) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier_reg[0]) begin
        acc_reg <= acc_reg + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  // sign applied on the way out
  assign resp_result = neg_reg ? result_t'(-acc_reg) : acc_reg;

endmodule

// ==== imuldiv_pkg.sv ====
/*
 * shared types and constants for the iterative mul/div unit
 * order queue depth is assumed a power of two for the pointer wrap
 */
package imuldiv_pkg;

  // ------------------------------------------------------------
  // function codes carried on the request stream
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,  // signed multiply, full 64-bit product
    FN_DIV  = 2'd1,  // signed divide, {rem, quo}
    FN_DIVU = 2'd2   // unsigned divide, {rem, quo}
  } imuldiv_fn_e;

  // datapath widths
  typedef logic [31:0] operand_t;
  typedef logic [63:0] result_t;

  // one shift step per operand bit
  localparam int ITER_COUNT = 32;
  typedef logic [5:0] iter_count_t;

  // ------------------------------------------------------------
  // order queue
  // ------------------------------------------------------------
  // max accepted requests not yet answered
  localparam int ORDER_DEPTH = 4;
  typedef logic [$clog2(ORDER_DEPTH)-1:0] order_ptr_t;
  typedef logic [$clog2(ORDER_DEPTH):0]   order_cnt_t;

  // unit tag held in each queue entry
  typedef logic unit_sel_t;
  localparam unit_sel_t UNIT_MUL = 1'b0;
  localparam unit_sel_t UNIT_DIV = 1'b1;

  // unit state machines
  typedef enum logic [1:0] {MUL_IDLE, MUL_CALC, MUL_DONE} mul_state_e;
  typedef enum logic [1:0] {DIV_IDLE, DIV_CALC, DIV_FIX, DIV_DONE} div_state_e;

endpackage
